/* rbk_reg_pkg.sv */
package rbk_reg_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int DATA_W    = 32;
  localparam int OFFSET_W  = 12;   // byte offset, 4 KB window
  localparam int REQ_PD_W  = 63;
  localparam int RESP_PD_W = 34;

  // request packet fields
  localparam int REQ_ADDR_LSB    = 0;
  localparam int REQ_ADDR_MSB    = 21;  // word address
  localparam int REQ_WDAT_LSB    = 22;  // 32 bits of write data
  localparam int REQ_WRITE_BIT   = 54;
  localparam int REQ_NPOSTED_BIT = 55;  // byte enables, priv, level above are not decoded

  // response packet fields
  localparam int RESP_ERR_BIT  = 32;
  localparam int RESP_KIND_BIT = 33;  // 0 read, 1 write

  //////////////////////////////
  // register map
  //////////////////////////////
  localparam logic [OFFSET_W-1:0] OFS_STATUS        = 12'h000;
  localparam logic [OFFSET_W-1:0] OFS_POINTER       = 12'h004;
  localparam logic [OFFSET_W-1:0] OFS_OP_ENABLE     = 12'h008;
  localparam logic [OFFSET_W-1:0] OFS_MISC_CFG      = 12'h00c;
  localparam logic [OFFSET_W-1:0] OFS_DAIN_ADDR_LOW = 12'h010;
  localparam logic [OFFSET_W-1:0] OFS_DATAIN_SIZE_0 = 12'h014;
  localparam logic [OFFSET_W-1:0] OFS_DATAIN_SIZE_1 = 12'h018;

  // first offset of the ping-pong groups, general section below
  localparam logic [OFFSET_W-1:0] GROUP_BASE = OFS_OP_ENABLE;

  // field widths
  localparam int MODE_W     = 2;
  localparam int PREC_W     = 2;
  localparam int ADDR_LOW_W = 27;
  localparam int DIM_W      = 13;

  // field positions inside their registers
  localparam int MODE_LSB     = 0;   // misc_cfg
  localparam int PREC_LSB     = 8;   // misc_cfg
  localparam int ADDR_LOW_LSB = 5;   // 32 byte aligned
  localparam int WIDTH_LSB    = 0;   // datain_size_0
  localparam int HEIGHT_LSB   = 16;  // datain_size_0
  localparam int CHANNEL_LSB  = 0;   // datain_size_1
  localparam int CONS_LSB     = 16;  // consumer inside pointer

  // per group status, group g at bits 2g+1..2g
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_PENDING = 2'd1;
  localparam logic [1:0] ST_RUNNING = 2'd2;

  localparam int OP_EN_DELAY = 3;  // datapath enable pipe depth

  // pointer width for a group count, never zero
  function automatic int ptr_w(int num_groups);
    return (num_groups > 1) ? $clog2(num_groups) : 1;
  endfunction

endpackage

/* rbk_access_if.sv */
interface rbk_access_if;
  import rbk_reg_pkg::*;

  logic [OFFSET_W-1:0] offset;   // byte offset of current request
  logic [DATA_W-1:0]   wr_data;
  logic                wr_en;    // one cycle per registered write

  // request decoder side
  modport dec (
    output offset,
    output wr_data,
    output wr_en
  );

  // general section and groups
  modport sink (
    input offset,
    input wr_data,
    input wr_en
  );

endinterface

/* rbk_cfg_if.sv */
interface rbk_cfg_if;
  import rbk_reg_pkg::*;

  logic [MODE_W-1:0]     mode;
  logic [PREC_W-1:0]     precision;
  logic [ADDR_LOW_W-1:0] addr_low;
  logic [DIM_W-1:0]      width;
  logic [DIM_W-1:0]      height;
  logic [DIM_W-1:0]      channel;
  logic                  op_en;
  logic [DATA_W-1:0]     rd_data;  // zero unless group addressed

  // driven by one group
  modport grp (
    output mode, precision, addr_low,
    output width, height, channel,
    output op_en, rd_data
  );

  // read by the selector
  modport sel (
    input mode, precision, addr_low,
    input width, height, channel,
    input op_en, rd_data
  );

endinterface

/* rbk_csb_req.sv */
module rbk_csb_req (
  input  logic                               nvdla_core_clk,
  input  logic                               nvdla_core_rstn,
  input  logic                               req_pvld,
  input  logic [rbk_reg_pkg::REQ_PD_W-1:0]   req_pd,
  output logic                               req_prdy,
  output logic                               resp_valid,
  output logic [rbk_reg_pkg::RESP_PD_W-1:0]  resp_pd,
  input  logic [rbk_reg_pkg::DATA_W-1:0]     rd_data,
  rbk_access_if.dec                          acc
);
  import rbk_reg_pkg::*;

  logic                                 req_vld_q;
  logic [REQ_NPOSTED_BIT:0]             req_pd_q;   // only decoded bits kept
  logic [REQ_ADDR_MSB-REQ_ADDR_LSB:0]   req_addr;
  logic [DATA_W-1:0]                    req_wdat;
  logic                                 req_write;
  logic                                 req_nposted;
  logic                                 rd_en;
  logic                                 wr_en;
  logic [RESP_PD_W-1:0]                 rresp_pd;
  logic [RESP_PD_W-1:0]                 wresp_pd;

  assign req_prdy = 1'b1;  // never stalls

  //////////////////////////////
  // request capture
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_pd_q <= req_pd[REQ_NPOSTED_BIT:0];  // hold last packet
    end
  end

  // unpack
  assign req_addr    = req_pd_q[REQ_ADDR_MSB:REQ_ADDR_LSB];
  assign req_wdat    = req_pd_q[REQ_WDAT_LSB +: DATA_W];
  assign req_write   = req_pd_q[REQ_WRITE_BIT];
  assign req_nposted = req_pd_q[REQ_NPOSTED_BIT];

  assign rd_en = req_vld_q & ~req_write;
  assign wr_en = req_vld_q & req_write;

  // word address to byte offset
  assign acc.offset  = {req_addr[OFFSET_W-3:0], 2'b00};
  assign acc.wr_data = req_wdat;
  assign acc.wr_en   = wr_en;

  //////////////////////////////
  // responses
  //////////////////////////////
  always_comb begin
    rresp_pd                = '0;
    rresp_pd[DATA_W-1:0]    = rd_data;   // state before this cycle's write
    rresp_pd[RESP_ERR_BIT]  = 1'b0;
    rresp_pd[RESP_KIND_BIT] = 1'b0;      // read
    wresp_pd                = '0;        // write ack carries no data
    wresp_pd[RESP_ERR_BIT]  = 1'b0;
    wresp_pd[RESP_KIND_BIT] = 1'b1;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
      resp_pd    <= '0;
    end else begin
      resp_valid <= rd_en | (wr_en & req_nposted);  // posted writes are silent
      if (rd_en) begin
        resp_pd <= rresp_pd;
      end else if (wr_en & req_nposted) begin
        resp_pd <= wresp_pd;
      end
    end
  end

endmodule

/* rbk_ptr_ctrl.sv */
module rbk_ptr_ctrl #(
  parameter int NUM_GROUPS = 2
) (
  input  logic                                           nvdla_core_clk,
  input  logic                                           nvdla_core_rstn,
  rbk_access_if.sink                                     acc,
  input  logic                                           done,
  input  logic [NUM_GROUPS-1:0]                          op_en,
  output logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]      producer,
  output logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]      consumer,
  output logic [rbk_reg_pkg::DATA_W-1:0]                 rd_data
);
  import rbk_reg_pkg::*;

  localparam int PTR_W = ptr_w(NUM_GROUPS);

  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] pointer_word;

  //////////////////////////////
  // pointers
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= '0;
    end else if (acc.wr_en && acc.offset == OFS_POINTER) begin
      producer <= acc.wr_data[PTR_W-1:0];  // sw picks group to program
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= '0;
    end else if (done) begin
      // wrap at last group
      consumer <= (consumer == PTR_W'(NUM_GROUPS - 1)) ? '0 : consumer + 1'b1;
    end
  end

  // status per group
  always_comb begin
    status_word = '0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (!op_en[g]) begin
        status_word[2*g +: 2] = ST_IDLE;
      end else if (consumer == PTR_W'(g)) begin
        status_word[2*g +: 2] = ST_RUNNING;  // datapath on it
      end else begin
        status_word[2*g +: 2] = ST_PENDING;  // armed, waiting its turn
      end
    end
  end

  always_comb begin
    pointer_word                     = '0;
    pointer_word[PTR_W-1:0]          = producer;
    pointer_word[CONS_LSB +: PTR_W]  = consumer;  // read only
  end

  // general read back, groups and holes give zero
  always_comb begin
    case (acc.offset)
      OFS_STATUS:  rd_data = status_word;
      OFS_POINTER: rd_data = pointer_word;
      default:     rd_data = '0;
    endcase
  end

endmodule

/* rbk_reg_group.sv */
module rbk_reg_group #(
  parameter int NUM_GROUPS = 2,
  parameter int GROUP_ID   = 0
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  rbk_access_if.sink                                 acc,
  input  logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]  producer,
  input  logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]  consumer,
  input  logic                                       done,
  rbk_cfg_if.grp                                     cfg
);
  import rbk_reg_pkg::*;

  localparam int PTR_W = ptr_w(NUM_GROUPS);

  logic                  sel;       // this group addressed
  logic                  wr_ok;     // write allowed, group idle
  logic                  op_en;
  logic [MODE_W-1:0]     mode;
  logic [PREC_W-1:0]     precision;
  logic [ADDR_LOW_W-1:0] addr_low;
  logic [DIM_W-1:0]      width;
  logic [DIM_W-1:0]      height;
  logic [DIM_W-1:0]      channel;
  logic [DATA_W-1:0]     rd_word;

  assign sel   = (acc.offset >= GROUP_BASE) && (producer == PTR_W'(GROUP_ID));
  assign wr_ok = acc.wr_en & sel & ~op_en;  // locked while enabled

  //////////////////////////////
  // config fields
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mode      <= '0;
      precision <= '0;
      addr_low  <= '0;
      width     <= '0;
      height    <= '0;
      channel   <= '0;
    end else if (wr_ok) begin
      case (acc.offset)
        OFS_MISC_CFG: begin
          mode      <= acc.wr_data[MODE_LSB +: MODE_W];
          precision <= acc.wr_data[PREC_LSB +: PREC_W];
        end
        OFS_DAIN_ADDR_LOW: addr_low <= acc.wr_data[ADDR_LOW_LSB +: ADDR_LOW_W];
        OFS_DATAIN_SIZE_0: begin
          width  <= acc.wr_data[WIDTH_LSB +: DIM_W];
          height <= acc.wr_data[HEIGHT_LSB +: DIM_W];
        end
        OFS_DATAIN_SIZE_1: channel <= acc.wr_data[CHANNEL_LSB +: DIM_W];
        default: ;  // op_enable handled below
      endcase
    end
  end

  // op enable, set by sw, cleared by done while consumed
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en <= 1'b0;
    end else if (wr_ok && acc.offset == OFS_OP_ENABLE) begin
      op_en <= acc.wr_data[0];
    end else if (done && consumer == PTR_W'(GROUP_ID)) begin
      op_en <= 1'b0;
    end
  end

  // read back in register layout
  always_comb begin
    rd_word = '0;
    if (sel) begin
      case (acc.offset)
        OFS_OP_ENABLE: rd_word[0] = op_en;
        OFS_MISC_CFG: begin
          rd_word[MODE_LSB +: MODE_W] = mode;
          rd_word[PREC_LSB +: PREC_W] = precision;
        end
        OFS_DAIN_ADDR_LOW: rd_word[ADDR_LOW_LSB +: ADDR_LOW_W] = addr_low;  // low bits zero
        OFS_DATAIN_SIZE_0: begin
          rd_word[WIDTH_LSB +: DIM_W]  = width;
          rd_word[HEIGHT_LSB +: DIM_W] = height;
        end
        OFS_DATAIN_SIZE_1: rd_word[CHANNEL_LSB +: DIM_W] = channel;
        default: rd_word = '0;
      endcase
    end
  end

  assign cfg.mode      = mode;
  assign cfg.precision = precision;
  assign cfg.addr_low  = addr_low;
  assign cfg.width     = width;
  assign cfg.height    = height;
  assign cfg.channel   = channel;
  assign cfg.op_en     = op_en;
  assign cfg.rd_data   = rd_word;

endmodule

/* rbk_cfg_select.sv */
module rbk_cfg_select #(
  parameter int NUM_GROUPS = 2
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  rbk_cfg_if.sel                                     cfg [NUM_GROUPS],
  input  logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]  consumer,
  input  logic                                       done,
  input  logic [rbk_reg_pkg::DATA_W-1:0]             gen_rd_data,
  output logic [rbk_reg_pkg::DATA_W-1:0]             rd_data,
  output logic                                       op_en_out,
  output logic [rbk_reg_pkg::MODE_W-1:0]             mode,
  output logic [rbk_reg_pkg::PREC_W-1:0]             precision,
  output logic [rbk_reg_pkg::ADDR_LOW_W-1:0]         addr_low,
  output logic [rbk_reg_pkg::DIM_W-1:0]              width,
  output logic [rbk_reg_pkg::DIM_W-1:0]              height,
  output logic [rbk_reg_pkg::DIM_W-1:0]              channel
);
  import rbk_reg_pkg::*;

  logic [NUM_GROUPS-1:0][MODE_W-1:0]     mode_a;
  logic [NUM_GROUPS-1:0][PREC_W-1:0]     prec_a;
  logic [NUM_GROUPS-1:0][ADDR_LOW_W-1:0] addr_a;
  logic [NUM_GROUPS-1:0][DIM_W-1:0]      width_a;
  logic [NUM_GROUPS-1:0][DIM_W-1:0]      height_a;
  logic [NUM_GROUPS-1:0][DIM_W-1:0]      chan_a;
  logic [NUM_GROUPS-1:0][DATA_W-1:0]     rd_a;
  logic [NUM_GROUPS-1:0]                 op_en_a;
  logic [OP_EN_DELAY-1:0]                op_en_pipe;

  // flatten the interface array so it can be indexed at run time
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_unpack
    assign mode_a[g]   = cfg[g].mode;
    assign prec_a[g]   = cfg[g].precision;
    assign addr_a[g]   = cfg[g].addr_low;
    assign width_a[g]  = cfg[g].width;
    assign height_a[g] = cfg[g].height;
    assign chan_a[g]   = cfg[g].channel;
    assign rd_a[g]     = cfg[g].rd_data;
    assign op_en_a[g]  = cfg[g].op_en;
  end

  // at most one source non zero
  always_comb begin
    rd_data = gen_rd_data;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      rd_data = rd_data | rd_a[g];
    end
  end

  //////////////////////////////
  // consumer group to datapath
  //////////////////////////////
  assign mode      = mode_a[consumer];
  assign precision = prec_a[consumer];
  assign addr_low  = addr_a[consumer];
  assign width     = width_a[consumer];
  assign height    = height_a[consumer];
  assign channel   = chan_a[consumer];

  // delayed enable, flushed by done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (done) begin
      op_en_pipe <= '0;
    end else begin
      op_en_pipe <= {op_en_pipe[OP_EN_DELAY-2:0], op_en_a[consumer]};
    end
  end

  assign op_en_out = op_en_pipe[OP_EN_DELAY-1];

endmodule

/* rbk_regfile.sv */
module rbk_regfile #(
  parameter int NUM_GROUPS = 2  // power of two
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  input  logic                                       csb2rbk_req_pvld,
  input  logic [rbk_reg_pkg::REQ_PD_W-1:0]           csb2rbk_req_pd,
  output logic                                       csb2rbk_req_prdy,
  output logic                                       rbk2csb_resp_valid,
  output logic [rbk_reg_pkg::RESP_PD_W-1:0]          rbk2csb_resp_pd,
  input  logic                                       dp2reg_done,
  output logic [rbk_reg_pkg::ptr_w(NUM_GROUPS)-1:0]  dp2reg_consumer,
  output logic                                       reg2dp_op_en,
  output logic [rbk_reg_pkg::MODE_W-1:0]             reg2dp_rubik_mode,
  output logic [rbk_reg_pkg::PREC_W-1:0]             reg2dp_in_precision,
  output logic [rbk_reg_pkg::ADDR_LOW_W-1:0]         reg2dp_dain_addr_low,
  output logic [rbk_reg_pkg::DIM_W-1:0]              reg2dp_datain_width,
  output logic [rbk_reg_pkg::DIM_W-1:0]              reg2dp_datain_height,
  output logic [rbk_reg_pkg::DIM_W-1:0]              reg2dp_datain_channel
);
  import rbk_reg_pkg::*;

  localparam int PTR_W = ptr_w(NUM_GROUPS);

  logic [PTR_W-1:0]      producer;
  logic [NUM_GROUPS-1:0] grp_op_en;
  logic [DATA_W-1:0]     gen_rd_data;  // general section
  logic [DATA_W-1:0]     rd_data;      // merged

  rbk_access_if acc_if ();
  rbk_cfg_if    cfg_if [NUM_GROUPS] ();

  // csb side
  rbk_csb_req u_csb_req (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_pvld        (csb2rbk_req_pvld),
    .req_pd          (csb2rbk_req_pd),
    .req_prdy        (csb2rbk_req_prdy),
    .resp_valid      (rbk2csb_resp_valid),
    .resp_pd         (rbk2csb_resp_pd),
    .rd_data         (rd_data),
    .acc             (acc_if)
  );

  rbk_ptr_ctrl #(.NUM_GROUPS(NUM_GROUPS)) u_ptr_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .acc             (acc_if),
    .done            (dp2reg_done),
    .op_en           (grp_op_en),
    .producer        (producer),
    .consumer        (dp2reg_consumer),
    .rd_data         (gen_rd_data)
  );

  //////////////////////////////
  // ping-pong groups
  //////////////////////////////
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_grp
    rbk_reg_group #(.NUM_GROUPS(NUM_GROUPS), .GROUP_ID(g)) u_reg_group (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .acc             (acc_if),
      .producer        (producer),
      .consumer        (dp2reg_consumer),
      .done            (dp2reg_done),
      .cfg             (cfg_if[g])
    );
    assign grp_op_en[g] = cfg_if[g].op_en;  // for status
  end

  rbk_cfg_select #(.NUM_GROUPS(NUM_GROUPS)) u_cfg_select (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg_if),
    .consumer        (dp2reg_consumer),
    .done            (dp2reg_done),
    .gen_rd_data     (gen_rd_data),
    .rd_data         (rd_data),
    .op_en_out       (reg2dp_op_en),
    .mode            (reg2dp_rubik_mode),
    .precision       (reg2dp_in_precision),
    .addr_low        (reg2dp_dain_addr_low),
    .width           (reg2dp_datain_width),
    .height          (reg2dp_datain_height),
    .channel         (reg2dp_datain_channel)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // reset low from time zero, released on a falling edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RESET_CYCLES) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

/* tb_rbk_regfile.sv */
module tb_rbk_regfile;
  import rbk_reg_pkg::*;

  localparam int NG       = 2;
  localparam int PW       = ptr_w(NG);
  localparam int WAIT_MAX = 40;  // cycles per wait

  logic                  nvdla_core_clk;
  logic                  nvdla_core_rstn;
  logic                  csb2rbk_req_pvld;
  logic [REQ_PD_W-1:0]   csb2rbk_req_pd;
  logic                  csb2rbk_req_prdy;
  logic                  rbk2csb_resp_valid;
  logic [RESP_PD_W-1:0]  rbk2csb_resp_pd;
  logic                  dp2reg_done;
  logic [PW-1:0]         dp2reg_consumer;
  logic                  reg2dp_op_en;
  logic [MODE_W-1:0]     reg2dp_rubik_mode;
  logic [PREC_W-1:0]     reg2dp_in_precision;
  logic [ADDR_LOW_W-1:0] reg2dp_dain_addr_low;
  logic [DIM_W-1:0]      reg2dp_datain_width;
  logic [DIM_W-1:0]      reg2dp_datain_height;
  logic [DIM_W-1:0]      reg2dp_datain_channel;

  //////////////////////////////
  // reference model state
  //////////////////////////////
  int unsigned           m_producer;
  int unsigned           m_consumer;
  logic                  m_op_en [NG];
  logic [MODE_W-1:0]     m_mode [NG];
  logic [PREC_W-1:0]     m_prec [NG];
  logic [ADDR_LOW_W-1:0] m_addr [NG];
  logic [DIM_W-1:0]      m_width [NG];
  logic [DIM_W-1:0]      m_height [NG];
  logic [DIM_W-1:0]      m_chan [NG];

  logic [RESP_PD_W-1:0]  exp_q [$];  // responses still owed by the DUT
  int                    errors;
  int                    checks;
  int                    test_err0;
  bit                    timed_out;
  logic [31:0]           seed;
  logic [OFFSET_W-1:0]   rnd_ofs;
  int                    n;

  tb_clk_gen clk_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  rbk_regfile #(.NUM_GROUPS(NG)) rbk_regfile_inst (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .csb2rbk_req_pvld      (csb2rbk_req_pvld),
    .csb2rbk_req_pd        (csb2rbk_req_pd),
    .csb2rbk_req_prdy      (csb2rbk_req_prdy),
    .rbk2csb_resp_valid    (rbk2csb_resp_valid),
    .rbk2csb_resp_pd       (rbk2csb_resp_pd),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_consumer       (dp2reg_consumer),
    .reg2dp_op_en          (reg2dp_op_en),
    .reg2dp_rubik_mode     (reg2dp_rubik_mode),
    .reg2dp_in_precision   (reg2dp_in_precision),
    .reg2dp_dain_addr_low  (reg2dp_dain_addr_low),
    .reg2dp_datain_width   (reg2dp_datain_width),
    .reg2dp_datain_height  (reg2dp_datain_height),
    .reg2dp_datain_channel (reg2dp_datain_channel)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected read data before the request's own write
  function automatic logic [DATA_W-1:0] exp_rd(logic [OFFSET_W-1:0] ofs);
    logic [DATA_W-1:0] d;
    int unsigned       p;
    d = '0;
    p = m_producer;
    if (ofs == OFS_STATUS) begin
      for (int g = 0; g < NG; g++) begin
        d[2*g +: 2] = !m_op_en[g] ? ST_IDLE : (m_consumer == g) ? ST_RUNNING : ST_PENDING;
      end
    end else if (ofs == OFS_POINTER) begin
      d = m_producer | (m_consumer << 16);  // consumer from bit 16
    end else begin
      case (ofs)
        OFS_OP_ENABLE:     d[0] = m_op_en[p];
        OFS_MISC_CFG:      d = {22'd0, m_prec[p], 6'd0, m_mode[p]};
        OFS_DAIN_ADDR_LOW: d = {m_addr[p], 5'd0};
        OFS_DATAIN_SIZE_0: d = {3'd0, m_height[p], 3'd0, m_width[p]};
        OFS_DATAIN_SIZE_1: d = {19'd0, m_chan[p]};
        default:           d = '0;  // holes
      endcase
    end
    return d;
  endfunction

  // expected datapath config of the consumer group
  function automatic logic [95:0] exp_cfg();
    int unsigned c;
    c = m_consumer;
    return {m_mode[c], m_prec[c], m_addr[c], m_width[c], m_height[c], m_chan[c]};
  endfunction

  function automatic void model_write(logic [OFFSET_W-1:0] ofs, logic [DATA_W-1:0] d);
    int unsigned p;
    p = m_producer;
    if (ofs == OFS_POINTER) begin
      m_producer = d[PW-1:0];
    end else if (ofs >= GROUP_BASE && !m_op_en[p]) begin  // enabled group is locked
      case (ofs)
        OFS_OP_ENABLE: m_op_en[p] = d[0];
        OFS_MISC_CFG: begin
          m_mode[p] = d[1:0];
          m_prec[p] = d[9:8];
        end
        OFS_DAIN_ADDR_LOW: m_addr[p] = d[31:5];
        OFS_DATAIN_SIZE_0: begin
          m_width[p]  = d[12:0];
          m_height[p] = d[28:16];
        end
        OFS_DATAIN_SIZE_1: m_chan[p] = d[12:0];
        default: ;
      endcase
    end
  endfunction

  task automatic check_value(string what, logic [95:0] got, logic [95:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // one request from falling edge to falling edge
  task automatic bus_access(logic write, logic nposted, logic [OFFSET_W-1:0] ofs,
                            logic [DATA_W-1:0] d);
    logic [REQ_PD_W-1:0]  pd;
    logic [RESP_PD_W-1:0] exp;
    int                   cnt;
    if (timed_out) return;
    pd                            = '0;
    pd[REQ_ADDR_MSB:REQ_ADDR_LSB] = ofs >> 2;  // word address
    pd[REQ_WDAT_LSB +: DATA_W]    = d;
    pd[REQ_WRITE_BIT]             = write;
    pd[REQ_NPOSTED_BIT]           = nposted;
    exp = '0;
    if (!write) begin
      exp[DATA_W-1:0] = exp_rd(ofs);
      exp_q.push_back(exp);
    end else begin
      if (nposted) begin
        exp[RESP_KIND_BIT] = 1'b1;  // write ack with zero data
        exp_q.push_back(exp);
      end
      model_write(ofs, d);
    end
    csb2rbk_req_pvld = 1'b1;
    csb2rbk_req_pd   = pd;
    @(negedge nvdla_core_clk);
    csb2rbk_req_pvld = 1'b0;
    if (write && !nposted) begin
      @(negedge nvdla_core_clk);  // a stray response would show here
    end else begin
      cnt = 0;
      do begin
        @(negedge nvdla_core_clk);
        cnt++;
      end while (!rbk2csb_resp_valid && cnt < WAIT_MAX);
      if (!rbk2csb_resp_valid) begin
        timed_out = 1'b1;
        $display("timeout: no response to the request at offset 0x%h", ofs);
      end
    end
  endtask

  task automatic reg_read(logic [OFFSET_W-1:0] ofs);
    bus_access(1'b0, 1'b0, ofs, '0);
  endtask

  task automatic wait_op_en(logic level);
    int cnt;
    if (timed_out) return;
    cnt = 0;
    while (reg2dp_op_en !== level && cnt < WAIT_MAX) begin
      @(negedge nvdla_core_clk);
      cnt++;
    end
    if (reg2dp_op_en !== level) begin
      timed_out = 1'b1;
      $display("timeout: reg2dp_op_en never reached %0b", level);
    end
  endtask

  task automatic pulse_done();
    dp2reg_done = 1'b1;
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b0;
    m_op_en[m_consumer] = 1'b0;
    m_consumer          = (m_consumer + 1) % NG;
  endtask

  task automatic check_datapath(string what);
    check_value(what, {reg2dp_rubik_mode, reg2dp_in_precision, reg2dp_dain_addr_low,
                       reg2dp_datain_width, reg2dp_datain_height, reg2dp_datain_channel},
                exp_cfg());
  endtask

  // report a test once its owed responses are checked
  task automatic end_test(string name);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && !timed_out && cnt < WAIT_MAX) begin
      @(negedge nvdla_core_clk);
      cnt++;
    end
    if (exp_q.size() != 0 && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: %0d responses never arrived", exp_q.size());
    end
    $display("test %s: %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // response checker on the falling edge where resp is stable
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn && rbk2csb_resp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected response from the DUT with no request outstanding at %0t",
                 $time);
      end else begin
        check_value("response", rbk2csb_resp_pd, exp_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    csb2rbk_req_pvld = 1'b0;
    csb2rbk_req_pd   = '0;
    dp2reg_done      = 1'b0;
    errors    = 0;
    checks    = 0;
    test_err0 = 0;
    timed_out = 1'b0;
    seed      = 32'hf677_ca89;
    m_producer = 0;
    m_consumer = 0;
    for (int g = 0; g < NG; g++) begin
      m_op_en[g]  = 1'b0;
      m_mode[g]   = '0;
      m_prec[g]   = '0;
      m_addr[g]   = '0;
      m_width[g]  = '0;
      m_height[g] = '0;
      m_chan[g]   = '0;
    end
    n = 0;
    do begin
      @(negedge nvdla_core_clk);
      n++;
    end while (nvdla_core_rstn !== 1'b1 && n < WAIT_MAX);
    if (nvdla_core_rstn !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
    @(negedge nvdla_core_clk);

    // reset values
    check_value("req ready", csb2rbk_req_prdy, 1);
    check_value("resp valid", rbk2csb_resp_valid, 0);
    check_value("op_en", reg2dp_op_en, 0);
    check_value("consumer", dp2reg_consumer, 0);
    reg_read(OFS_STATUS);
    reg_read(OFS_POINTER);
    end_test("reset");

    // group 0 fields with mixed posted and non-posted writes
    bus_access(1'b1, 1'b1, OFS_MISC_CFG, 32'h0000_0203);
    bus_access(1'b1, 1'b0, OFS_DAIN_ADDR_LOW, 32'h1234_567f);  // low 5 bits dropped
    bus_access(1'b1, 1'b1, OFS_DATAIN_SIZE_0, 32'hffff_ffff);
    bus_access(1'b1, 1'b0, OFS_DATAIN_SIZE_1, 32'h0000_1abc);
    reg_read(OFS_MISC_CFG);
    reg_read(OFS_DAIN_ADDR_LOW);
    reg_read(OFS_DATAIN_SIZE_0);
    reg_read(OFS_DATAIN_SIZE_1);
    reg_read(12'h01c);
    reg_read(12'h100);
    reg_read(12'hffc);
    end_test("fields");

    // arm group 0 as the running group
    bus_access(1'b1, 1'b1, OFS_OP_ENABLE, 32'h1);
    reg_read(OFS_STATUS);
    wait_op_en(1'b1);
    check_datapath("config g0");
    bus_access(1'b1, 1'b1, OFS_MISC_CFG, 32'h0000_0101);  // locked
    reg_read(OFS_MISC_CFG);
    reg_read(OFS_OP_ENABLE);
    end_test("enable");

    // program group 1 behind it and hand over on done
    bus_access(1'b1, 1'b0, OFS_POINTER, 32'h1);
    reg_read(OFS_POINTER);
    bus_access(1'b1, 1'b0, OFS_MISC_CFG, 32'h0000_0102);
    bus_access(1'b1, 1'b0, OFS_DAIN_ADDR_LOW, 32'hdead_bee0);
    bus_access(1'b1, 1'b0, OFS_DATAIN_SIZE_0, 32'h0040_0020);
    bus_access(1'b1, 1'b0, OFS_DATAIN_SIZE_1, 32'h0000_0010);
    bus_access(1'b1, 1'b1, OFS_OP_ENABLE, 32'h1);
    reg_read(OFS_STATUS);
    pulse_done();
    check_value("op_en flushed", reg2dp_op_en, 0);
    check_value("consumer", dp2reg_consumer, m_consumer);
    check_datapath("config g1");
    reg_read(OFS_STATUS);
    reg_read(OFS_POINTER);
    wait_op_en(1'b1);
    end_test("ping-pong");

    // random fields into idle group 0
    bus_access(1'b1, 1'b1, OFS_POINTER, 32'h0);
    for (int i = 0; i < 16; i++) begin
      seed = lcg_next(seed);
      case (seed[31:30])
        2'd0:    rnd_ofs = OFS_MISC_CFG;
        2'd1:    rnd_ofs = OFS_DAIN_ADDR_LOW;
        2'd2:    rnd_ofs = OFS_DATAIN_SIZE_0;
        default: rnd_ofs = OFS_DATAIN_SIZE_1;
      endcase
      seed = lcg_next(seed);
      bus_access(1'b1, seed[20], rnd_ofs, seed);
      reg_read(rnd_ofs);
    end
    check_datapath("config kept");
    end_test("random");

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* vlog.f */
rbk_reg_pkg.sv
rbk_access_if.sv
rbk_cfg_if.sv
rbk_csb_req.sv
rbk_ptr_ctrl.sv
rbk_reg_group.sv
rbk_cfg_select.sv
rbk_regfile.sv
tb_clk_gen.sv
tb_rbk_regfile.sv

/* Bender.yml */
package:
  name: rbk_regfile

sources:
  - rbk_reg_pkg.sv
  - rbk_access_if.sv
  - rbk_cfg_if.sv
  - rbk_csb_req.sv
  - rbk_ptr_ctrl.sv
  - rbk_reg_group.sv
  - rbk_cfg_select.sv
  - rbk_regfile.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_rbk_regfile.sv
